// File: Makefile
TOP := tb_soc_domain

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Simulation completed successfully" > /dev/null

clean:
	rm -rf obj_dir

// File: sim.f
source/soc_pkg.sv
source/req_port.sv
source/req_fifo.sv
source/mem_ctrl_sbr.sv
source/soc_domain.sv
tests/soc_domain_props.sv
tests/tb_soc_domain.sv

// File: source/mem_ctrl_sbr.sv
// Serves one request per cycle at most; SRAM contents are undefined until written
`timescale 1ns/1ns

module mem_ctrl_sbr (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  // From the request buffer
  input  logic                          empty_i,
  input  soc_pkg::req_t                 pop_data_i,
  output logic                          pop_o,

  // Response channel
  output logic                          rsp_valid_o,
  output soc_pkg::rsp_t                 rsp_o,
  input  logic                          rsp_ready_i,

  // SoC control outputs
  output logic [soc_pkg::DataWidth-1:0] boot_addr_o,
  output logic                          fetch_en_o
);

  import soc_pkg::*;

  localparam int unsigned SramIdxWidth = $clog2(SramNumWords);

  logic [DataWidth-1:0]    sram_q [SramNumWords];
  logic [SramIdxWidth-1:0] sram_idx;
  logic [DataWidth-1:0]    boot_addr_q;
  logic                    fetch_en_q;
  logic                    sram_sel;
  logic                    boot_sel;
  logic                    fetch_sel;
  logic                    addr_err;
  logic                    wr_en;
  logic                    rsp_valid_q;
  rsp_t                    rsp_q;
  rsp_t                    rsp_d;

  // Merge write data into an old word under byte enables
  function automatic logic [DataWidth-1:0] be_merge(input logic [DataWidth-1:0] old_w,
                                                    input logic [DataWidth-1:0] new_w,
                                                    input logic [BeWidth-1:0]   be);
    logic [DataWidth-1:0] res;
    res = old_w;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // ------------------------------------------------
  // Address decode
  // ------------------------------------------------
  assign sram_sel  = (pop_data_i.addr.mem.region == RegionSram) &&
                     (pop_data_i.addr.mem.word < SramNumWords);
  assign boot_sel  = (pop_data_i.addr.regs.region == RegionCtrl) &&
                     (pop_data_i.addr.regs.idx == IdxWidth'(RegBootAddr));
  assign fetch_sel = (pop_data_i.addr.regs.region == RegionCtrl) &&
                     (pop_data_i.addr.regs.idx == IdxWidth'(RegFetchEn));
  assign addr_err  = !(sram_sel || boot_sel || fetch_sel);
  assign sram_idx  = pop_data_i.addr.mem.word[SramIdxWidth-1:0];

  // Pop when the response slot is empty or draining this cycle
  assign pop_o = !empty_i && (!rsp_valid_q || rsp_ready_i);
  assign wr_en = pop_o && pop_data_i.we && !addr_err;

  always_comb begin
    rsp_d.err   = 1'b0;
    rsp_d.rdata = '0;
    if (addr_err) begin
      rsp_d.err   = 1'b1;
      rsp_d.rdata = ErrRspData;
    end else if (!pop_data_i.we) begin
      if (sram_sel) begin
        rsp_d.rdata = sram_q[sram_idx];
      end else if (boot_sel) begin
        rsp_d.rdata = boot_addr_q;
      end else begin
        rsp_d.rdata = {{(DataWidth-1){1'b0}}, fetch_en_q};
      end
    end
  end

  // ------------------------------------------------
  // Storage
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (wr_en && sram_sel) begin
      sram_q[sram_idx] <= be_merge(sram_q[sram_idx], pop_data_i.wdata, pop_data_i.be);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      boot_addr_q <= BootAddrDefault;
      fetch_en_q  <= 1'b0;
    end else if (wr_en) begin
      if (boot_sel) begin
        boot_addr_q <= be_merge(boot_addr_q, pop_data_i.wdata, pop_data_i.be);
      end
      // Only bit 0 is implemented
      if (fetch_sel && pop_data_i.be[0]) begin
        fetch_en_q <= pop_data_i.wdata[0];
      end
    end
  end

  // Response register
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (pop_o) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;
  assign boot_addr_o = boot_addr_q;
  assign fetch_en_o  = fetch_en_q;

endmodule

// File: source/req_fifo.sv
// In-order request buffer; a push while full or a pop while empty is ignored
`timescale 1ns/1ns

module req_fifo #(
  parameter int unsigned Depth = soc_pkg::FifoDepth
) (
  input  logic          clk_i,
  input  logic          rst_n_i,

  input  logic          push_i,
  input  soc_pkg::req_t push_data_i,
  output logic          full_o,

  input  logic          pop_i,
  output soc_pkg::req_t pop_data_o,
  output logic          empty_o
);

  import soc_pkg::*;

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  req_t                mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                do_push;
  logic                do_pop;

  assign full_o  = (count_q == CntWidth'(Depth));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Head entry is always visible
  assign pop_data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // ------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// File: source/req_port.sv
// Four-phase request side; req_data_i must stay stable while req_i is high and ack_o is low
`timescale 1ns/1ns

module req_port (
  input  logic         clk_i,
  input  logic         rst_n_i,

  // Four-phase request from outside
  input  logic         req_i,
  input  soc_pkg::req_t req_data_i,
  output logic         ack_o,

  // Towards the request buffer
  output logic         push_o,
  output soc_pkg::req_t push_data_o,
  input  logic         full_i
);

  typedef enum logic {
    Idle,
    Acked
  } state_e;

  state_e state_q;
  state_e state_d;

  // ------------------------------------------------
  // Handshake FSM
  // ------------------------------------------------
  always_comb begin
    state_d = state_q;
    push_o  = 1'b0;
    unique case (state_q)
      Idle: begin
        // Accept only when the buffer has room
        if (req_i && !full_i) begin
          push_o  = 1'b1;
          state_d = Acked;
        end
      end
      Acked: begin
        // Wait for the outside to drop req
        if (!req_i) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // ack is the registered state, high from the edge after the push
  assign ack_o       = (state_q == Acked);
  assign push_data_o = req_data_i;

endmodule

// File: source/soc_domain.sv
// Request side is four-phase, response side valid/ready; responses come back in request order
`timescale 1ns/1ns

module soc_domain (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  input  logic                          req_i,
  input  soc_pkg::req_t                 req_data_i,
  output logic                          ack_o,

  output logic                          rsp_valid_o,
  output soc_pkg::rsp_t                 rsp_o,
  input  logic                          rsp_ready_i,

  output logic [soc_pkg::DataWidth-1:0] boot_addr_o,
  output logic                          fetch_en_o
);

  import soc_pkg::*;

  // ------------------------------------------------
  // Internal request path
  // ------------------------------------------------
  logic push;
  req_t push_data;
  logic full;
  logic pop;
  req_t pop_data;
  logic empty;

  req_port i_req_port (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .req_i       ( req_i      ),
    .req_data_i  ( req_data_i ),
    .ack_o       ( ack_o      ),
    .push_o      ( push       ),
    .push_data_o ( push_data  ),
    .full_i      ( full       )
  );

  req_fifo #(
    .Depth ( FifoDepth )
  ) i_req_fifo (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .push_i      ( push      ),
    .push_data_i ( push_data ),
    .full_o      ( full      ),
    .pop_i       ( pop       ),
    .pop_data_o  ( pop_data  ),
    .empty_o     ( empty     )
  );

  // Memory, control registers and error path
  mem_ctrl_sbr i_mem_ctrl_sbr (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .empty_i     ( empty       ),
    .pop_data_i  ( pop_data    ),
    .pop_o       ( pop         ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_o       ( rsp_o       ),
    .rsp_ready_i ( rsp_ready_i ),
    .boot_addr_o ( boot_addr_o ),
    .fetch_en_o  ( fetch_en_o  )
  );

endmodule

// File: source/soc_pkg.sv
// Single bus manager only; addresses are word aligned and the byte offset is never decoded
package soc_pkg;

  // ------------------------------------------------
  // Bus geometry
  // ------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // Region select sits in the top nibble
  localparam int unsigned RegionMsb = AddrWidth - 1;
  localparam int unsigned RegionLsb = AddrWidth - 4;
  localparam int unsigned IdxWidth  = AddrWidth - (RegionMsb - RegionLsb + 1) - 2;

  localparam logic [RegionMsb-RegionLsb:0] RegionSram = 4'd0;
  localparam logic [RegionMsb-RegionLsb:0] RegionCtrl = 4'd1;

  // ------------------------------------------------
  // Memory bank and control registers
  // ------------------------------------------------
  localparam int unsigned SramNumWords    = 256;
  localparam int unsigned RegBootAddr     = 0;
  localparam int unsigned RegFetchEn      = 1;
  localparam logic [DataWidth-1:0] BootAddrDefault = 32'h1000_0000;
  localparam logic [DataWidth-1:0] ErrRspData      = 32'hBADCAB1E;

  // Request buffer entries
  localparam int unsigned FifoDepth = 4;

  // Address as seen by the memory bank
  typedef struct packed {
    logic [RegionMsb-RegionLsb:0] region;
    logic [IdxWidth-1:0]          word;
    logic [1:0]                   offset;
  } mem_addr_t;

  // Same bits, seen as a control register index
  typedef struct packed {
    logic [RegionMsb-RegionLsb:0] region;
    logic [IdxWidth-1:0]          idx;
    logic [1:0]                   offset;
  } reg_addr_t;

  typedef union packed {
    mem_addr_t mem;
    reg_addr_t regs;
  } addr_u;

  typedef struct packed {
    logic                 we;
    logic [BeWidth-1:0]   be;
    addr_u                addr;
    logic [DataWidth-1:0] wdata;
  } req_t;

  typedef struct packed {
    logic                 err;
    logic [DataWidth-1:0] rdata;
  } rsp_t;

endpackage

// File: tests/soc_domain_props.sv
// Top-level handshake rules only; internal buffer state is not observed here
`timescale 1ns/1ns

module soc_domain_props (
  input logic          clk_i,
  input logic          rst_n_i,
  input logic          req_i,
  input logic          ack_o,
  input logic          rsp_valid_o,
  input soc_pkg::rsp_t rsp_o,
  input logic          rsp_ready_i
);

  // ------------------------------------------------
  // Request handshake
  // ------------------------------------------------
  ack_rise_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(ack_o) |-> $past(req_i))
    else $error("ack_o rose without req_i high");

  ack_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ack_o && req_i) |=> ack_o)
    else $error("ack_o dropped while req_i was still high");

  // Response held under back-pressure
  rsp_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o)))
    else $error("rsp_o changed while stalled");

  reset_a: assert property (@(posedge clk_i)
    !rst_n_i |=> (!ack_o && !rsp_valid_o))
    else $error("ack_o or rsp_valid_o high after reset");

endmodule

bind soc_domain soc_domain_props i_soc_domain_props (
  .clk_i       ( clk_i       ),
  .rst_n_i     ( rst_n_i     ),
  .req_i       ( req_i       ),
  .ack_o       ( ack_o       ),
  .rsp_valid_o ( rsp_valid_o ),
  .rsp_o       ( rsp_o       ),
  .rsp_ready_i ( rsp_ready_i )
);

// File: tests/tb_soc_domain.sv
// Random traffic reads only SRAM words 0 to 15, which the fill phase writes first
`timescale 1ns/1ns

module tb_soc_domain;

  import soc_pkg::*;

  localparam int unsigned NumFill       = 16;
  localparam int unsigned NumRand       = 60;
  // Directed phases issue fewer than 60 requests
  localparam int unsigned NumTxn        = 60 + NumRand;
  localparam int unsigned TimeoutCycles = NumTxn * 40 + 500;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 req_i;
  req_t                 req_data_i;
  logic                 ack_o;
  logic                 rsp_valid_o;
  rsp_t                 rsp_o;
  logic                 rsp_ready_i;
  logic [DataWidth-1:0] boot_addr_o;
  logic                 fetch_en_o;

  // Reference model state
  logic [DataWidth-1:0] model_mem [SramNumWords];
  logic [DataWidth-1:0] model_boot;
  logic                 model_fetch;

  req_t        exp_q [$];
  req_t        rand_reqs [NumRand];
  logic [31:0] lfsr_q;
  logic        rand_ready;
  logic        full_idle_q;
  int unsigned n_errors = 0;
  int unsigned n_checks = 0;
  int unsigned n_sent   = 0;
  int unsigned n_rcvd   = 0;
  int unsigned n_full   = 0;

  soc_domain soc_domain_i (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .req_i       ( req_i       ),
    .req_data_i  ( req_data_i  ),
    .ack_o       ( ack_o       ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_o       ( rsp_o       ),
    .rsp_ready_i ( rsp_ready_i ),
    .boot_addr_o ( boot_addr_o ),
    .fetch_en_o  ( fetch_en_o  )
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int unsigned n, output logic [31:0] v);
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[31]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  function automatic logic [31:0] apply_be(input logic [31:0] old_w, input logic [31:0] new_w,
                                           input logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] sram_addr(input int unsigned idx);
    return idx << 2;
  endfunction

  function automatic logic [31:0] ctrl_addr(input int unsigned idx);
    return 32'h1000_0000 | (idx << 2);
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5A3C_96E1;
  endfunction

  function automatic req_t make_req(input logic we, input logic [3:0] be,
                                    input logic [31:0] addr, input logic [31:0] wdata);
    req_t r;
    r.we    = we;
    r.be    = be;
    r.addr  = addr;
    r.wdata = wdata;
    return r;
  endfunction

  // ------------------------------------------------
  // Reference model
  // ------------------------------------------------
  function automatic rsp_t ref_response(input req_t r);
    rsp_t                 res;
    logic [AddrWidth-1:0] a;
    logic                 is_sram;
    logic                 is_boot;
    logic                 is_fetch;
    logic [DataWidth-1:0] merged;
    a         = r.addr;
    is_sram   = (a[31:28] == RegionSram) && (a[27:2] < 26'(SramNumWords));
    is_boot   = (a[31:28] == RegionCtrl) && (a[27:2] == 26'(RegBootAddr));
    is_fetch  = (a[31:28] == RegionCtrl) && (a[27:2] == 26'(RegFetchEn));
    res.err   = 1'b0;
    res.rdata = '0;
    if (!(is_sram || is_boot || is_fetch)) begin
      res.err   = 1'b1;
      res.rdata = ErrRspData;
    end else if (r.we) begin
      if (is_sram) begin
        model_mem[a[9:2]] = apply_be(model_mem[a[9:2]], r.wdata, r.be);
      end else if (is_boot) begin
        model_boot = apply_be(model_boot, r.wdata, r.be);
      end else begin
        merged      = apply_be({31'b0, model_fetch}, r.wdata, r.be);
        model_fetch = merged[0];
      end
    end else if (is_sram) begin
      res.rdata = model_mem[a[9:2]];
    end else if (is_boot) begin
      res.rdata = model_boot;
    end else begin
      res.rdata = {31'b0, model_fetch};
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    n_checks++;
    if (got !== expected) begin
      n_errors++;
      $display("** Error: %s is %h, expected %h at %0t", name, got, expected, $time);
    end
  endtask

  // One four-phase handshake
  task automatic send_req(input req_t r);
    @(negedge clk_i);
    req_i      = 1'b1;
    req_data_i = r;
    exp_q.push_back(r);
    n_sent++;
    @(negedge clk_i);
    while (!ack_o) @(negedge clk_i);
    // Every other request keeps req high one more cycle after ack
    if (n_sent % 2 == 0) begin
      @(negedge clk_i);
    end
    req_i = 1'b0;
    @(negedge clk_i);
    while (ack_o) @(negedge clk_i);
  endtask

  task automatic wait_responses();
    while (exp_q.size() != 0) @(negedge clk_i);
  endtask

  // ------------------------------------------------
  // Response compare and buffer-full monitor
  // ------------------------------------------------
  always @(posedge clk_i) begin
    req_t r;
    rsp_t e;
    if (rst_n_i && rsp_valid_o && rsp_ready_i) begin
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("Error: a response arrived with no outstanding request at %0t", $time);
      end else begin
        r = exp_q.pop_front();
        e = ref_response(r);
        n_rcvd++;
        check_value("rsp_o.err", {31'b0, rsp_o.err}, {31'b0, e.err});
        check_value("rsp_o.rdata", rsp_o.rdata, e.rdata);
        check_value("boot_addr_o", boot_addr_o, model_boot);
        check_value("fetch_en_o", {31'b0, fetch_en_o}, {31'b0, model_fetch});
      end
    end
  end

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_idle_q <= 1'b0;
    end else begin
      if (full_idle_q && ack_o) begin
        n_errors++;
        $display("Error: ack_o rose while the request buffer was full at %0t", $time);
      end
      full_idle_q <= soc_domain_i.full && !ack_o;
      if (soc_domain_i.full) begin
        n_full++;
      end
    end
  end

  // Random back-pressure, ready about one cycle in eight
  always @(negedge clk_i) begin
    logic [31:0] bits;
    if (rand_ready) begin
      take_bits(3, bits);
      rsp_ready_i = &bits[2:0];
    end
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    logic [31:0] bits;
    logic [31:0] wd;
    logic [31:0] a;
    lfsr_q      = 32'hcb06a128;
    rst_n_i     = 1'b0;
    req_i       = 1'b0;
    req_data_i  = '0;
    rsp_ready_i = 1'b0;
    rand_ready  = 1'b0;
    model_boot  = BootAddrDefault;
    model_fetch = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_n_i     = 1'b1;
    rsp_ready_i = 1'b1;
    check_value("ack_o", {31'b0, ack_o}, 32'h0);
    check_value("rsp_valid_o", {31'b0, rsp_valid_o}, 32'h0);
    check_value("fetch_en_o", {31'b0, fetch_en_o}, 32'h0);
    check_value("boot_addr_o", boot_addr_o, BootAddrDefault);

    // SRAM fill, byte-enable merges, read back
    for (int unsigned i = 0; i < NumFill; i++) begin
      send_req(make_req(1'b1, 4'hf, sram_addr(i), fill_word(sram_addr(i))));
    end
    for (int unsigned i = 0; i < 8; i++) begin
      send_req(make_req(1'b1, 4'(3 * i + 1), sram_addr(2 * i), 32'hA5C3_0F69 ^ i));
    end
    for (int unsigned i = 0; i < NumFill; i++) begin
      send_req(make_req(1'b0, 4'h0, sram_addr(i), '0));
    end

    // Control registers
    send_req(make_req(1'b1, 4'hf, ctrl_addr(RegBootAddr), 32'h2000_0400));
    send_req(make_req(1'b0, 4'h0, ctrl_addr(RegBootAddr), '0));
    send_req(make_req(1'b1, 4'b0011, ctrl_addr(RegBootAddr), 32'hFFFF_1234));
    send_req(make_req(1'b0, 4'h0, ctrl_addr(RegBootAddr), '0));
    send_req(make_req(1'b1, 4'hf, ctrl_addr(RegFetchEn), 32'hFFFF_FFFF));
    send_req(make_req(1'b0, 4'h0, ctrl_addr(RegFetchEn), '0));
    send_req(make_req(1'b1, 4'b1110, ctrl_addr(RegFetchEn), 32'h0));
    send_req(make_req(1'b0, 4'h0, ctrl_addr(RegFetchEn), '0));
    send_req(make_req(1'b1, 4'b0001, ctrl_addr(RegFetchEn), 32'h0000_0002));
    send_req(make_req(1'b0, 4'h0, ctrl_addr(RegFetchEn), '0));

    // Error paths, then confirm nothing changed
    send_req(make_req(1'b1, 4'hf, 32'h2000_0010, 32'hDEAD_0001));
    send_req(make_req(1'b0, 4'h0, 32'hF000_0000, '0));
    send_req(make_req(1'b1, 4'hf, sram_addr(SramNumWords), 32'hDEAD_0002));
    send_req(make_req(1'b0, 4'h0, sram_addr(1000), '0));
    send_req(make_req(1'b1, 4'hf, ctrl_addr(2), 32'hDEAD_0003));
    send_req(make_req(1'b0, 4'h0, ctrl_addr(7), '0));
    send_req(make_req(1'b0, 4'h0, ctrl_addr(RegBootAddr), '0));
    send_req(make_req(1'b0, 4'h0, ctrl_addr(RegFetchEn), '0));
    send_req(make_req(1'b0, 4'h0, sram_addr(0), '0));

    // Random burst under back-pressure
    for (int i = 0; i < NumRand; i++) begin
      take_bits(11, bits);
      case (bits[1:0])
        2'd0: a = sram_addr(32'(bits[5:2]));
        2'd1: a = sram_addr(SramNumWords + 32'(bits[5:2]) * 37);
        2'd2: a = ctrl_addr(32'(bits[3:2]));
        default: a = {4'd2 + {1'b0, bits[4:2]}, 28'h000_0100};
      endcase
      take_bits(32, wd);
      rand_reqs[i] = make_req(bits[10], bits[9:6], a, wd);
    end
    wait_responses();
    @(posedge clk_i);
    rand_ready = 1'b1;
    for (int i = 0; i < NumRand; i++) begin
      send_req(rand_reqs[i]);
    end
    wait_responses();
    @(posedge clk_i);
    rand_ready = 1'b0;
    @(negedge clk_i);
    rsp_ready_i = 1'b1;
    repeat (4) @(negedge clk_i);

    if (n_full == 0) begin
      n_errors++;
      $display("Error: the request buffer never filled during the random burst");
    end
    if (n_rcvd != n_sent) begin
      n_errors++;
      $display("Error: %0d requests sent but %0d responses received", n_sent, n_rcvd);
    end
    $display("Checks: %0d, errors: %0d, requests: %0d, responses: %0d",
             n_checks, n_errors, n_sent, n_rcvd);
    if (n_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
